// File: rtl/bp_pkg.sv
////////////////////////////////////////////////////////////
// Branch predictor package
// Widths, table index layout, counter encodings and the
// clear controller state type
////////////////////////////////////////////////////////////

package bp_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  localparam int XLEN              = 32;
  localparam int BP_GLOBAL_BITS    = 2;  // Global history bits in the index
  localparam int BP_LOCAL_BITS     = 6;  // PC bits in the index
  localparam int BP_LOCAL_BITS_LSB = 2;  // Word aligned instructions
  localparam int INDEX_BITS        = BP_GLOBAL_BITS + BP_LOCAL_BITS;
  localparam int TABLE_DEPTH       = 1 << INDEX_BITS;

  typedef logic [XLEN-1:0]           pc_t;
  typedef logic [BP_GLOBAL_BITS-1:0] history_t;
  typedef logic [INDEX_BITS-1:0]     bp_index_t;
  typedef logic [1:0]                bp_count_t;  // MSB set means taken

  ////////////////////////////////////////////////////////////
  // Counter encodings
  localparam bp_count_t STRONG_NOT_TAKEN = 2'd0;
  localparam bp_count_t WEAK_NOT_TAKEN   = 2'd1;
  localparam bp_count_t WEAK_TAKEN       = 2'd2;
  localparam bp_count_t STRONG_TAKEN     = 2'd3;

  // Clear controller states
  typedef enum logic
  {
    CLEAR,
    READY
  } clear_state_t;

  // Table index, history above the PC bits
  function automatic bp_index_t bp_make_index(input pc_t pc, input history_t history);
    bp_index_t idx;
    idx = {history, pc[BP_LOCAL_BITS_LSB +: BP_LOCAL_BITS]};
    return idx;
  endfunction

endpackage

// File: rtl/bp_write_if.sv
////////////////////////////////////////////////////////////
// Counter table write port
// Single cycle write, no acknowledge
////////////////////////////////////////////////////////////

interface bp_write_if;

  logic              we;     // Write on rising edge
  bp_pkg::bp_index_t waddr;
  bp_pkg::bp_count_t wdata;

  // Write driver side
  modport ctrl
  (
    output we,
    output waddr,
    output wdata
  );

  // Storage side
  modport tbl
  (
    input we,
    input waddr,
    input wdata
  );

endinterface

// File: rtl/bp_table.sv
////////////////////////////////////////////////////////////
// Branch prediction counter table
// One registered read port holding on stall, one write port
////////////////////////////////////////////////////////////

module bp_table
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              stall_i,      // Decoder stalled, hold prediction

  input  bp_pkg::bp_index_t rd_index_i,
  output bp_pkg::bp_count_t rd_count_o,

  bp_write_if.tbl           wr
);

  ////////////////////////////////////////////////////////////
  // Storage
  //
  bp_pkg::bp_count_t mem [bp_pkg::TABLE_DEPTH];

  // Filled by the clear walk after reset
  always_ff @(posedge clk_i)
  begin
    if (wr.we)
    begin
      mem[wr.waddr] <= wr.wdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read port
  //

  // Same entry read and written on one edge returns the old value
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rd_count_o <= bp_pkg::STRONG_NOT_TAKEN;
    end
    else if (!stall_i)
    begin
      rd_count_o <= mem[rd_index_i];
    end
  end

endmodule

// File: rtl/bp_update.sv
////////////////////////////////////////////////////////////
// Branch resolve feedback
// Table index and next saturated counter for a resolved branch
////////////////////////////////////////////////////////////

module bp_update
(
  input  logic                update_i,          // Branch resolved
  input  bp_pkg::pc_t         update_pc_i,
  input  bp_pkg::history_t    update_history_i,
  input  bp_pkg::bp_count_t   update_predict_i,  // Counter used for the prediction
  input  logic                update_taken_i,    // Actual outcome

  output logic                req_o,
  output bp_pkg::bp_index_t   req_index_o,
  output bp_pkg::bp_count_t   req_count_o
);

  // Request valid in the same cycle as the resolve
  assign req_o       = update_i;
  assign req_index_o = bp_pkg::bp_make_index(update_pc_i, update_history_i);

  ////////////////////////////////////////////////////////////
  // Saturating step toward the outcome
  //
  always_comb
  begin
    if (update_taken_i)
    begin
      if (update_predict_i == bp_pkg::STRONG_TAKEN)
      begin
        req_count_o = bp_pkg::STRONG_TAKEN;          // Saturate high
      end
      else
      begin
        req_count_o = update_predict_i + 2'd1;
      end
    end
    else
    begin
      if (update_predict_i == bp_pkg::STRONG_NOT_TAKEN)
      begin
        req_count_o = bp_pkg::STRONG_NOT_TAKEN;      // Saturate low
      end
      else
      begin
        req_count_o = update_predict_i - 2'd1;
      end
    end
  end

endmodule

// File: rtl/bp_clear_ctrl.sv
////////////////////////////////////////////////////////////
// Table clear controller
// Walks the table with weakly not taken after reset, then
// forwards branch updates to the write port
////////////////////////////////////////////////////////////

module bp_clear_ctrl
(
  input  logic              clk_i,
  input  logic              rst_n_i,

  // Update request from the branch unit side
  input  logic              req_i,
  input  bp_pkg::bp_index_t req_index_i,
  input  bp_pkg::bp_count_t req_count_i,

  bp_write_if.ctrl          wr,

  output logic              ready_o
);

  ////////////////////////////////////////////////////////////
  // State
  //
  bp_pkg::clear_state_t state_q;
  bp_pkg::bp_index_t    clr_addr_q;    // Next entry to clear
  logic                 clr_last;

  assign clr_last = (clr_addr_q == bp_pkg::bp_index_t'(bp_pkg::TABLE_DEPTH - 1));

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q    <= bp_pkg::CLEAR;
      clr_addr_q <= '0;
    end
    else
    begin
      case (state_q)
        bp_pkg::CLEAR:
        begin
          clr_addr_q <= clr_addr_q + 1'b1;
          if (clr_last)
          begin
            state_q <= bp_pkg::READY;  // Last entry written this edge
          end
        end
        default:
        begin
          state_q <= bp_pkg::READY;    // Stays until next reset
        end
      endcase
    end
  end

  // Ready one edge after the last clear write
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ready_o <= 1'b0;
    end
    else
    begin
      ready_o <= (state_q == bp_pkg::READY);
    end
  end

  ////////////////////////////////////////////////////////////
  // Write port select
  //
  always_comb
  begin
    if (state_q == bp_pkg::CLEAR)
    begin
      wr.we    = 1'b1;
      wr.waddr = clr_addr_q;
      wr.wdata = bp_pkg::WEAK_NOT_TAKEN;
    end
    else
    begin
      wr.we    = req_i & ready_o;  // Updates before ready are dropped
      wr.waddr = req_index_i;
      wr.wdata = req_count_i;
    end
  end

endmodule

// File: rtl/branch_predictor.sv
////////////////////////////////////////////////////////////
// Branch prediction unit
// Two bit saturating counter table indexed by PC and
// global history
////////////////////////////////////////////////////////////

module branch_predictor
(
  input  logic              clk_i,
  input  logic              rst_n_i,

  // Prediction read from fetch
  input  logic              stall_i,
  input  bp_pkg::pc_t       predict_pc_i,
  input  bp_pkg::history_t  predict_history_i,
  output bp_pkg::bp_count_t predict_o,

  // Update from the branch unit
  input  logic              update_i,
  input  bp_pkg::pc_t       update_pc_i,
  input  bp_pkg::history_t  update_history_i,
  input  bp_pkg::bp_count_t update_predict_i,
  input  logic              update_taken_i,

  output logic              ready_o          // Table clear done
);

  ////////////////////////////////////////////////////////////
  // Signals
  //
  bp_pkg::bp_index_t rd_index;
  logic              req;
  bp_pkg::bp_index_t req_index;
  bp_pkg::bp_count_t req_count;

  bp_write_if u_wr_if ();

  // History bits above the PC bits
  assign rd_index = bp_pkg::bp_make_index(predict_pc_i, predict_history_i);

  ////////////////////////////////////////////////////////////
  // Blocks
  //
  bp_table u_table (
    .clk_i      ( clk_i     ),
    .rst_n_i    ( rst_n_i   ),
    .stall_i    ( stall_i   ),
    .rd_index_i ( rd_index  ),
    .rd_count_o ( predict_o ),
    .wr         ( u_wr_if   )
  );

  bp_update u_update (
    .update_i         ( update_i         ),
    .update_pc_i      ( update_pc_i      ),
    .update_history_i ( update_history_i ),
    .update_predict_i ( update_predict_i ),
    .update_taken_i   ( update_taken_i   ),
    .req_o            ( req              ),
    .req_index_o      ( req_index        ),
    .req_count_o      ( req_count        )
  );

  bp_clear_ctrl u_clear_ctrl (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .req_i       ( req       ),
    .req_index_i ( req_index ),
    .req_count_i ( req_count ),
    .wr          ( u_wr_if   ),
    .ready_o     ( ready_o   )
  );

endmodule

// File: testbench/branch_predictor_checker.sv
////////////////////////////////////////////////////////////
// Branch predictor checker
// Shadow counter table and concurrent assertions
////////////////////////////////////////////////////////////

module branch_predictor_checker
(
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              stall_i,
  input bp_pkg::pc_t       predict_pc_i,
  input bp_pkg::history_t  predict_history_i,
  input bp_pkg::bp_count_t predict_o,
  input logic              update_i,
  input bp_pkg::pc_t       update_pc_i,
  input bp_pkg::history_t  update_history_i,
  input bp_pkg::bp_count_t update_predict_i,
  input logic              update_taken_i,
  input logic              ready_o
);

  int                fail_cnt = 0;
  int                edge_cnt;                       // Edges since reset release
  bp_pkg::bp_count_t shadow [bp_pkg::TABLE_DEPTH];
  bp_pkg::bp_count_t exp_q;                          // Expected prediction
  logic              exp_valid_q;
  bp_pkg::bp_index_t rd_idx;
  bp_pkg::bp_index_t up_idx;
  bp_pkg::bp_count_t up_next;

  assign rd_idx = {predict_history_i,
                   predict_pc_i[bp_pkg::BP_LOCAL_BITS_LSB +: bp_pkg::BP_LOCAL_BITS]};
  assign up_idx = {update_history_i,
                   update_pc_i[bp_pkg::BP_LOCAL_BITS_LSB +: bp_pkg::BP_LOCAL_BITS]};

  // One step toward the outcome, saturating at both ends
  always_comb
  begin
    if (update_taken_i)
      up_next = (update_predict_i == 2'd3) ? 2'd3 : update_predict_i + 2'd1;
    else
      up_next = (update_predict_i == 2'd0) ? 2'd0 : update_predict_i - 2'd1;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      edge_cnt    <= 0;
      exp_q       <= '0;
      exp_valid_q <= 1'b0;
      for (int i = 0; i < bp_pkg::TABLE_DEPTH; i++)
        shadow[i] <= bp_pkg::WEAK_NOT_TAKEN;
    end
    else
    begin
      if (edge_cnt <= bp_pkg::TABLE_DEPTH)
        edge_cnt <= edge_cnt + 1;
      if (!stall_i)
      begin
        exp_q       <= shadow[rd_idx];               // Old value on a collision
        exp_valid_q <= ready_o;
      end
      if (update_i && ready_o)
        shadow[up_idx] <= up_next;
    end
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  clear_time: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ready_o == (edge_cnt > bp_pkg::TABLE_DEPTH))
  else
  begin
    $error("error at %0t: ready_o is %0b, clear length is %0d cycles",
           $time, $sampled(ready_o), bp_pkg::TABLE_DEPTH);
    fail_cnt++;
  end

  ready_stays: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$fell(ready_o))
  else
  begin
    $error("ready_o fell after clear at time %0t", $time);
    fail_cnt++;
  end

  predict_value: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    exp_valid_q |-> predict_o == exp_q)
  else
  begin
    $error("error at %0t: predict_o %0d, expected %0d",
           $time, $sampled(predict_o), $sampled(exp_q));
    fail_cnt++;
  end

  stall_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stall_i |=> $stable(predict_o))
  else
  begin
    $error("error at %0t: predict_o changed under stall", $time);
    fail_cnt++;
  end

endmodule

bind branch_predictor branch_predictor_checker u_checker (.*);

// File: testbench/tb_branch_predictor.sv
////////////////////////////////////////////////////////////
// Branch predictor testbench
// Clear, update, saturation, stall and history sequences
////////////////////////////////////////////////////////////

module tb_branch_predictor;

  localparam int CYCLE_LIMIT = 4 * (bp_pkg::TABLE_DEPTH + 400);

  logic              clk_i;
  logic              rst_n_i;
  logic              stall_i;
  bp_pkg::pc_t       predict_pc_i;
  bp_pkg::history_t  predict_history_i;
  bp_pkg::bp_count_t predict_o;
  logic              update_i;
  bp_pkg::pc_t       update_pc_i;
  bp_pkg::history_t  update_history_i;
  bp_pkg::bp_count_t update_predict_i;
  logic              update_taken_i;
  logic              ready_o;

  logic [31:0] rnd_state = 32'ha1f9;
  int          cycles    = 0;
  int          tests     = 0;
  int          last_fail = 0;

  branch_predictor u_dut (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Run length guard
  always @(posedge clk_i)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic read_entry(input bp_pkg::pc_t pc, input bp_pkg::history_t hist,
                            output bp_pkg::bp_count_t val);
    @(posedge clk_i);
    predict_pc_i      <= pc;
    predict_history_i <= hist;
    stall_i           <= 1'b0;
    @(posedge clk_i);
    @(negedge clk_i);
    val = predict_o;
  endtask

  task automatic send_update(input bp_pkg::pc_t pc, input bp_pkg::history_t hist,
                             input bp_pkg::bp_count_t pred, input logic taken);
    @(posedge clk_i);
    update_i         <= 1'b1;
    update_pc_i      <= pc;
    update_history_i <= hist;
    update_predict_i <= pred;
    update_taken_i   <= taken;
    @(posedge clk_i);
    update_i <= 1'b0;
  endtask

  task automatic report_test(input string name);
    int now_fail;
    now_fail = u_dut.u_checker.fail_cnt;
    tests++;
    $display("test %-12s : %0d failures", name, now_fail - last_fail);
    last_fail = now_fail;
  endtask

  initial
  begin
    bp_pkg::bp_count_t val;
    bp_pkg::pc_t       pc;
    bp_pkg::history_t  hist;
    rst_n_i = 1'b0;
    stall_i = 1'b0;
    predict_pc_i = '0;
    predict_history_i = '0;
    update_i = 1'b0;
    update_pc_i = '0;
    update_history_i = '0;
    update_predict_i = '0;
    update_taken_i = 1'b0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Clear walk, checked by the clear timing assertion
    wait (ready_o);
    @(posedge clk_i);
    @(negedge clk_i);
    report_test("clear_time");

    for (int i = 0; i < 20; i++)
    begin
      rnd_state = lcg_next(rnd_state);
      read_entry(rnd_state, rnd_state[9:8], val);
    end
    report_test("clear_value");

    for (int i = 0; i < 20; i++)
    begin
      rnd_state = lcg_next(rnd_state);
      send_update(rnd_state, rnd_state[9:8], rnd_state[17:16], rnd_state[20]);
      read_entry(rnd_state, rnd_state[9:8], val);
    end
    // Read and write of one entry on the same edge
    @(posedge clk_i);
    predict_pc_i      <= 32'h40;
    predict_history_i <= 2'd1;
    update_i          <= 1'b1;
    update_pc_i       <= 32'h40;
    update_history_i  <= 2'd1;
    update_predict_i  <= bp_pkg::WEAK_TAKEN;
    update_taken_i    <= 1'b1;
    @(posedge clk_i);
    update_i <= 1'b0;
    read_entry(32'h40, 2'd1, val);
    report_test("update_read");

    pc   = 32'h84;
    hist = 2'd2;
    for (int i = 0; i < 10; i++)
    begin
      read_entry(pc, hist, val);
      send_update(pc, hist, val, i < 5);   // Taken first, then not taken
    end
    read_entry(pc, hist, val);
    report_test("saturation");

    read_entry(32'h10, 2'd0, val);
    @(posedge clk_i);
    stall_i <= 1'b1;
    for (int i = 0; i < 10; i++)
    begin
      rnd_state = lcg_next(rnd_state);
      @(posedge clk_i);
      predict_pc_i      <= rnd_state;
      predict_history_i <= rnd_state[5:4];
      send_update(rnd_state, rnd_state[5:4], rnd_state[9:8], rnd_state[12]);
    end
    @(posedge clk_i);
    stall_i <= 1'b0;
    report_test("stall");

    pc = 32'h2c;
    send_update(pc, 2'd3, bp_pkg::WEAK_TAKEN, 1'b1);
    for (int h = 0; h < 4; h++)
      read_entry(pc, h[1:0], val);
    report_test("history");

    repeat (4) @(posedge clk_i);
    $display("%0d tests run, %0d failures", tests, u_dut.u_checker.fail_cnt);
    if (u_dut.u_checker.fail_cnt == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// File: branch_predictor.f
rtl/bp_pkg.sv
rtl/bp_write_if.sv
rtl/bp_table.sv
rtl/bp_update.sv
rtl/bp_clear_ctrl.sv
rtl/branch_predictor.sv
testbench/branch_predictor_checker.sv
testbench/tb_branch_predictor.sv

// File: run.sh
#!/bin/sh
# Build and run the branch predictor testbench with Verilator
rm -f sim.log
verilator --binary --assert --timing -Wno-fatal -f branch_predictor.f \
  --top-module tb_branch_predictor -o sim_tb || exit 1
./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "Testbench passed" sim.log && exit 0 || exit 1
